// ==== vlog.f ====
ext_mem_pkg.sv
mem_bus_if.sv
l1_cache.sv
be_merge.sv
main_mem.sv
ext_mem.sv
tb_ext_mem.sv

// ==== tb_ext_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ext_mem;
   import ext_mem_pkg::*;

   // About 200 accesses with a line fill plus a waiting fill at worst
   localparam int MAX_ACCESSES        = 250;
   localparam int WORST_ACCESS_CYCLES = 40;
   localparam int TIMEOUT_CYCLES      = 2 * MAX_ACCESSES * WORST_ACCESS_CYCLES;

   localparam int    REGION_WORDS = 16;
   localparam int    N_CONC_OPS   = 20;
   localparam addr_t HIT_BASE     = 14'h0100;
   localparam addr_t MISS_BASE    = 14'h0200;
   localparam addr_t CONF_A       = 14'h0300;
   localparam addr_t CONF_B       = 14'h0340;  // Same index as CONF_A with another tag
   localparam addr_t STALE_ADDR   = 14'h0400;
   localparam addr_t I_BASE       = 14'h0800;
   localparam addr_t D_BASE       = 14'h0900;

   logic  clk_i;
   logic  arst_i;
   logic  inv_i;
   logic  i_req_i;
   addr_t i_addr_i;
   data_t i_wdata_i;
   strb_t i_wstrb_i;
   data_t i_rdata_o;
   logic  i_ack_o;
   logic  d_req_i;
   addr_t d_addr_i;
   data_t d_wdata_i;
   strb_t d_wstrb_i;
   data_t d_rdata_o;
   logic  d_ack_o;

   data_t ref_mem [addr_t];  // Expected memory contents
   int    cycle_cnt = 0;

   ext_mem UUT (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .inv_i    (inv_i),
      .i_req_i  (i_req_i),
      .i_addr_i (i_addr_i),
      .i_wdata_i(i_wdata_i),
      .i_wstrb_i(i_wstrb_i),
      .i_rdata_o(i_rdata_o),
      .i_ack_o  (i_ack_o),
      .d_req_i  (d_req_i),
      .d_addr_i (d_addr_i),
      .d_wdata_i(d_wdata_i),
      .d_wstrb_i(d_wstrb_i),
      .d_rdata_o(d_rdata_o),
      .d_ack_o  (d_ack_o)
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: run still busy after %0d cycles", cycle_cnt);
         fail_and_stop("timeout");
      end
   end

   task automatic fail_and_stop(input string why);
      $display("*** FAILED ***");
      $fatal(1, "Stopped: %s", why);
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         $display("** Error: %s expected %h actual %h", name, exp, act);
         fail_and_stop("data mismatch");
      end
   endtask

   task automatic check_ack(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error: %s expected %b actual %b", name, exp, act);
         fail_and_stop("ack level mismatch");
      end
   endtask

   // Byte-strobed update of the reference memory
   task automatic model_write(input addr_t a, input data_t d, input strb_t s);
      data_t w;
      if (ref_mem.exists(a)) begin
         w = ref_mem[a];
      end else begin
         w = 'x;
      end
      for (int b = 0; b < STRB_W; b++) begin
         if (s[b]) begin
            w[8*b +: 8] = d[8*b +: 8];
         end
      end
      ref_mem[a] = w;
   endtask

   task automatic model_lookup(input addr_t a, output data_t v);
      if (!ref_mem.exists(a)) begin
         $display("Reference model holds no word at address %h", a);
         fail_and_stop("read of an unwritten address");
      end else begin
         v = ref_mem[a];
      end
   endtask

   // One request on the data port with addr and strobes held through the ack cycle
   task automatic d_access(input addr_t a, input data_t wd, input strb_t s,
                           output data_t rd);
      @(negedge clk_i);
      d_req_i   = 1'b1;
      d_addr_i  = a;
      d_wdata_i = wd;
      d_wstrb_i = s;
      @(negedge clk_i);
      while (d_ack_o !== 1'b1) begin
         @(negedge clk_i);
      end
      rd      = d_rdata_o;
      d_req_i = 1'b0;
      @(negedge clk_i);
      check_ack("d_ack one cycle", 1'b0, d_ack_o);
   endtask

   task automatic i_access(input addr_t a, input data_t wd, input strb_t s,
                           output data_t rd);
      @(negedge clk_i);
      i_req_i   = 1'b1;
      i_addr_i  = a;
      i_wdata_i = wd;
      i_wstrb_i = s;
      @(negedge clk_i);
      while (i_ack_o !== 1'b1) begin
         @(negedge clk_i);
      end
      rd      = i_rdata_o;
      i_req_i = 1'b0;
      @(negedge clk_i);
      check_ack("i_ack one cycle", 1'b0, i_ack_o);
   endtask

   task automatic write_word(input bit on_i, input addr_t a, input data_t d, input strb_t s);
      data_t unused;
      if (on_i) begin
         i_access(a, d, s, unused);
      end else begin
         d_access(a, d, s, unused);
      end
      model_write(a, d, s);
   endtask

   task automatic read_check(input string name, input bit on_i, input addr_t a);
      data_t got;
      data_t exp;
      if (on_i) begin
         i_access(a, '0, '0, got);
      end else begin
         d_access(a, '0, '0, got);
      end
      model_lookup(a, exp);
      check_data(name, exp, got);
   endtask

   task automatic pulse_inv();
      @(negedge clk_i);
      inv_i = 1'b1;
      @(negedge clk_i);
      inv_i = 1'b0;
   endtask

   task automatic test_reset();
      arst_i = 1'b1;
      repeat (5) begin
         @(negedge clk_i);
         check_ack("reset i_ack", 1'b0, i_ack_o);
         check_ack("reset d_ack", 1'b0, d_ack_o);
      end
      arst_i = 1'b0;
      repeat (3) begin
         @(negedge clk_i);
         check_ack("idle i_ack", 1'b0, i_ack_o);
         check_ack("idle d_ack", 1'b0, d_ack_o);
      end
   endtask

   task automatic test_write_readback();
      for (int k = 0; k < REGION_WORDS; k++) begin
         write_word(1'b0, HIT_BASE + addr_t'(k), $urandom(), 4'hf);
      end
      for (int k = 0; k < REGION_WORDS; k++) begin
         read_check("readback after fill", 1'b0, HIT_BASE + addr_t'(k));
      end
      // Lines are cached now, so these are write hits
      for (int k = 0; k < REGION_WORDS; k++) begin
         write_word(1'b0, HIT_BASE + addr_t'(k), $urandom(), strb_t'($urandom_range(1, 15)));
      end
      for (int k = 0; k < REGION_WORDS; k++) begin
         read_check("write hit merge", 1'b0, HIT_BASE + addr_t'(k));
      end
      // Both write passes miss since nothing is read in between
      for (int k = 0; k < 8; k++) begin
         write_word(1'b0, MISS_BASE + addr_t'(k), $urandom(), 4'hf);
      end
      for (int k = 0; k < 8; k++) begin
         write_word(1'b0, MISS_BASE + addr_t'(k), $urandom(), strb_t'($urandom_range(1, 15)));
      end
      for (int k = 0; k < 8; k++) begin
         read_check("no-allocate merge", 1'b0, MISS_BASE + addr_t'(k));
      end
   endtask

   task automatic test_conflict_miss();
      for (int k = 0; k < WORDS_PER_LINE; k++) begin
         write_word(1'b0, CONF_A + addr_t'(k), $urandom(), 4'hf);
         write_word(1'b0, CONF_B + addr_t'(k), $urandom(), 4'hf);
      end
      for (int r = 0; r < WORDS_PER_LINE; r++) begin
         read_check("d conflict A", 1'b0, CONF_A + addr_t'(r));
         read_check("d conflict B", 1'b0, CONF_B + addr_t'(r));
         read_check("i conflict A", 1'b1, CONF_A + addr_t'(r));
         read_check("i conflict B", 1'b1, CONF_B + addr_t'(r));
      end
   endtask

   task automatic test_inv_staleness();
      data_t old_word;
      data_t new_word;
      data_t got;
      old_word = $urandom();
      new_word = ~old_word;
      write_word(1'b0, STALE_ADDR, old_word, 4'hf);
      read_check("i first read", 1'b1, STALE_ADDR);
      write_word(1'b0, STALE_ADDR, new_word, 4'hf);
      i_access(STALE_ADDR, '0, '0, got);
      check_data("i stale read", old_word, got);  // No snooping between caches
      pulse_inv();
      i_access(STALE_ADDR, '0, '0, got);
      check_data("i read after inv", new_word, got);
   endtask

   // Random traffic of one port inside its own address range
   task automatic port_traffic(input bit on_i, input addr_t base);
      addr_t a;
      for (int k = 0; k < REGION_WORDS; k++) begin
         write_word(on_i, base + addr_t'(k), $urandom(), 4'hf);
      end
      for (int k = 0; k < N_CONC_OPS; k++) begin
         a = base + addr_t'($urandom_range(0, REGION_WORDS - 1));
         if ($urandom_range(0, 1) == 1) begin
            write_word(on_i, a, $urandom(), strb_t'($urandom_range(1, 15)));
         end else begin
            read_check(on_i ? "concurrent i read" : "concurrent d read", on_i, a);
         end
      end
   endtask

   task automatic test_concurrent();
      fork
         port_traffic(1'b1, I_BASE);
         port_traffic(1'b0, D_BASE);
      join
      // Instruction port writes must have reached memory
      for (int k = 0; k < REGION_WORDS; k++) begin
         read_check("d read of i writes", 1'b0, I_BASE + addr_t'(k));
      end
   endtask

   initial begin
      void'($urandom(32'he966_506d));
      clk_i     = 1'b0;
      arst_i    = 1'b1;
      inv_i     = 1'b0;
      i_req_i   = 1'b0;
      i_addr_i  = '0;
      i_wdata_i = '0;
      i_wstrb_i = '0;
      d_req_i   = 1'b0;
      d_addr_i  = '0;
      d_wdata_i = '0;
      d_wstrb_i = '0;

      test_reset();
      test_write_readback();
      test_conflict_miss();
      test_inv_staleness();
      test_concurrent();

      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== ext_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ext_mem (
   input  wire                     clk_i,
   input  wire                     arst_i,
   input  wire                     inv_i,   // Invalidates both caches
   // Instruction port
   input  wire                     i_req_i,
   input  wire ext_mem_pkg::addr_t i_addr_i,
   input  wire ext_mem_pkg::data_t i_wdata_i,
   input  wire ext_mem_pkg::strb_t i_wstrb_i,
   output ext_mem_pkg::data_t      i_rdata_o,
   output logic                    i_ack_o,
   // Data port
   input  wire                     d_req_i,
   input  wire ext_mem_pkg::addr_t d_addr_i,
   input  wire ext_mem_pkg::data_t d_wdata_i,
   input  wire ext_mem_pkg::strb_t d_wstrb_i,
   output ext_mem_pkg::data_t      d_rdata_o,
   output logic                    d_ack_o
);

   mem_bus_if ibe ();  // Instruction cache back end
   mem_bus_if dbe ();  // Data cache back end
   mem_bus_if mem ();  // Merged bus to memory

   l1_cache icache (
      .clk_i  (clk_i),
      .arst_i (arst_i),
      .inv_i  (inv_i),
      .req_i  (i_req_i),
      .addr_i (i_addr_i),
      .wdata_i(i_wdata_i),
      .wstrb_i(i_wstrb_i),
      .rdata_o(i_rdata_o),
      .ack_o  (i_ack_o),
      .be     (ibe.requester)
   );

   l1_cache dcache (
      .clk_i  (clk_i),
      .arst_i (arst_i),
      .inv_i  (inv_i),
      .req_i  (d_req_i),
      .addr_i (d_addr_i),
      .wdata_i(d_wdata_i),
      .wstrb_i(d_wstrb_i),
      .rdata_o(d_rdata_o),
      .ack_o  (d_ack_o),
      .be     (dbe.requester)
   );

   // Instruction side is master 0 and wins the first tie
   be_merge be_merge_u (
      .clk_i (clk_i),
      .arst_i(arst_i),
      .m0    (ibe.responder),
      .m1    (dbe.responder),
      .s     (mem.requester)
   );

   main_mem main_mem_u (
      .clk_i (clk_i),
      .arst_i(arst_i),
      .bus   (mem.responder)
   );

endmodule

`default_nettype wire

// ==== main_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_mem (
   input  wire          clk_i,
   input  wire          arst_i,
   mem_bus_if.responder bus
);
   import ext_mem_pkg::*;

   localparam int CNT_W = $clog2(MEM_LAT + 1);

   typedef logic [CNT_W-1:0] cnt_t;

   data_t mem [2**ADDR_W];
   cnt_t  lat_cnt_q;  // Cycles since the request was first seen

   assign bus.ack   = (lat_cnt_q == cnt_t'(MEM_LAT));
   assign bus.rdata = mem[bus.addr];

   // Counter starts on req and runs until the ack cycle
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         lat_cnt_q <= '0;
      end else if (bus.ack) begin
         lat_cnt_q <= '0;
      end else if (bus.req || (lat_cnt_q != '0)) begin
         lat_cnt_q <= lat_cnt_q + 1'b1;
      end
   end

   // Byte-strobed write lands in the ack cycle
   always_ff @(posedge clk_i) begin
      if (bus.ack) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (bus.wstrb[b]) begin
               mem[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== be_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module be_merge (
   input  wire          clk_i,
   input  wire          arst_i,
   mem_bus_if.responder m0,  // Instruction cache side
   mem_bus_if.responder m1,  // Data cache side
   mem_bus_if.requester s
);

   typedef enum logic {
      M_IDLE,
      M_BUSY
   } merge_state_t;

   merge_state_t state_q;
   logic         gnt_q;  // Last granted master, high for m1
   logic         busy;

   assign busy = (state_q == M_BUSY);

   // Steer the granted master onto the memory bus
   assign s.req   = busy && (gnt_q ? m1.req : m0.req);
   assign s.addr  = gnt_q ? m1.addr : m0.addr;
   assign s.wdata = gnt_q ? m1.wdata : m0.wdata;
   assign s.wstrb = gnt_q ? m1.wstrb : m0.wstrb;

   // Response goes back in the same cycle, only to the granted side
   assign m0.ack   = busy && !gnt_q && s.ack;
   assign m1.ack   = busy && gnt_q && s.ack;
   assign m0.rdata = gnt_q ? '0 : s.rdata;
   assign m1.rdata = gnt_q ? s.rdata : '0;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= M_IDLE;
         gnt_q   <= 1'b1;  // So the first tie goes to m0
      end else begin
         case (state_q)
            M_IDLE: begin
               if (m0.req || m1.req) begin
                  state_q <= M_BUSY;
                  if (m0.req && m1.req) begin
                     gnt_q <= !gnt_q;  // Alternate on contention
                  end else begin
                     gnt_q <= m1.req;
                  end
               end
            end
            M_BUSY: begin
               if (s.ack) begin
                  state_q <= M_IDLE;
               end
            end
            default: begin
               state_q <= M_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== l1_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_cache #(
   parameter int NLINES_W = 4
) (
   input  wire                     clk_i,
   input  wire                     arst_i,
   input  wire                     inv_i,
   input  wire                     req_i,
   input  wire ext_mem_pkg::addr_t addr_i,
   input  wire ext_mem_pkg::data_t wdata_i,
   input  wire ext_mem_pkg::strb_t wstrb_i,
   output ext_mem_pkg::data_t      rdata_o,
   output logic                    ack_o,
   mem_bus_if.requester            be
);
   import ext_mem_pkg::*;

   localparam int NLINES = 1 << NLINES_W;
   localparam int TAG_W  = ADDR_W - NLINES_W - OFFSET_W;

   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [NLINES_W-1:0] idx_t;
   typedef logic [OFFSET_W-1:0] off_t;

   typedef enum logic [1:0] {
      C_IDLE,
      C_LOOKUP,
      C_FILL,
      C_WRITE
   } cache_state_t;

   cache_state_t state_q;

   // Line storage
   logic [NLINES-1:0] valid_q;
   tag_t              tag_mem  [NLINES];
   data_t             data_mem [NLINES*WORDS_PER_LINE];

   off_t fill_cnt_q;  // Next word of the line to fetch
   logic inv_pend_q;  // Invalidate seen while busy
   logic wr_ack_q;    // Front-end ack of a finished write

   // Address split
   tag_t tag;
   idx_t idx;
   off_t off;
   logic hit;
   logic is_wr;

   assign {tag, idx, off} = addr_i;
   assign is_wr = |wstrb_i;
   assign hit   = valid_q[idx] && (tag_mem[idx] == tag);

   // Back-end requests come only from the fill and write states
   assign be.req   = (state_q == C_FILL) || (state_q == C_WRITE);
   assign be.addr  = (state_q == C_FILL) ? {tag, idx, fill_cnt_q} : addr_i;
   assign be.wdata = wdata_i;
   assign be.wstrb = (state_q == C_WRITE) ? wstrb_i : '0;  // Fill words are reads

   assign rdata_o = data_mem[{idx, off}];
   assign ack_o   = ((state_q == C_LOOKUP) && hit && !is_wr) || wr_ack_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= C_IDLE;
         valid_q    <= '0;
         fill_cnt_q <= '0;
         inv_pend_q <= 1'b0;
         wr_ack_q   <= 1'b0;
      end else begin
         wr_ack_q <= 1'b0;
         if (inv_i && (state_q != C_IDLE)) begin
            inv_pend_q <= 1'b1;  // Applied once back in idle
         end
         case (state_q)
            C_IDLE: begin
               if (inv_i || inv_pend_q) begin
                  valid_q    <= '0;
                  inv_pend_q <= 1'b0;
               end
               // Request still high in the write ack cycle is the old one
               if (req_i && !wr_ack_q) begin
                  state_q <= C_LOOKUP;
               end
            end
            C_LOOKUP: begin
               if (is_wr) begin
                  state_q <= C_WRITE;
               end else if (hit) begin
                  state_q <= C_IDLE;  // Read hit acked this cycle
               end else begin
                  state_q <= C_FILL;
               end
            end
            C_FILL: begin
               if (be.ack) begin
                  fill_cnt_q <= fill_cnt_q + 1'b1;  // Wraps to zero after the line
                  if (fill_cnt_q == '1) begin
                     valid_q[idx] <= 1'b1;
                     state_q      <= C_LOOKUP;  // Second lookup hits and acks
                  end
               end
            end
            C_WRITE: begin
               if (be.ack) begin
                  wr_ack_q <= 1'b1;
                  state_q  <= C_IDLE;
               end
            end
            default: begin
               state_q <= C_IDLE;
            end
         endcase
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk_i) begin
      if ((state_q == C_FILL) && be.ack) begin
         data_mem[{idx, fill_cnt_q}] <= be.rdata;
         if (fill_cnt_q == '1) begin
            tag_mem[idx] <= tag;
         end
      end
      // Write hit merges the strobed bytes, a miss leaves the line alone
      if ((state_q == C_WRITE) && be.ack && hit) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb_i[b]) begin
               data_mem[{idx, off}][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== mem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
   import ext_mem_pkg::*;

   // Request side, held stable until ack
   logic  req;
   addr_t addr;
   data_t wdata;
   strb_t wstrb;

   // Response side
   data_t rdata;  // Valid with ack on a read
   logic  ack;    // Single-cycle pulse

   modport requester (
      output req,
      output addr,
      output wdata,
      output wstrb,
      input  rdata,
      input  ack
   );

   modport responder (
      input  req,
      input  addr,
      input  wdata,
      input  wstrb,
      output rdata,
      output ack
   );

endinterface

`default_nettype wire

// ==== ext_mem_pkg.sv ====
`default_nettype none

package ext_mem_pkg;

   // Bus word and address widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 14;  // Word address, 64 KiB in total
   localparam int STRB_W = DATA_W / 8;

   // Cache line geometry
   localparam int OFFSET_W       = 2;
   localparam int WORDS_PER_LINE = 1 << OFFSET_W;

   // Main memory request to ack, in cycles
   localparam int MEM_LAT = 2;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [STRB_W-1:0] strb_t;  // All zero for a read

endpackage

`default_nettype wire
